//--- bank_ctrl.sv
/*
   Bank controller with the register-file word memory
   Executes one request per pop and keeps the result
   in a one-entry output stage
*/

`timescale 1ns/1ps

module bank_ctrl
(
   input  logic           clk,
   input  logic           rst_n,
   // Requests from the request FIFO
   input  bus_pkg::req_t  req_i,
   input  logic           req_valid_i,
   output logic           req_grant_o,
   // Results towards the response FIFO
   output bus_pkg::resp_t resp_o,
   output logic           resp_valid_o,
   input  logic           resp_grant_i
);

   import bus_pkg::*;

   localparam int WORDS = 2 ** ADDR_W;

   logic [DATA_W-1:0] mem_q [WORDS];
   logic [DATA_W-1:0] rdata;
   logic              pop;
   resp_t             resp_q;
   logic              resp_valid_q;

   // Pop when the output stage is free or drains on this edge
   assign req_grant_o = !resp_valid_q || resp_grant_i;
   assign pop         = req_valid_i && req_grant_o;

   // Writes echo their own data
   assign rdata = req_i.we ? req_i.wdata : mem_q[req_i.addr];

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < WORDS; i++)
         begin
            mem_q[i] <= '0;
         end
      end
      else if (pop && req_i.we)
      begin
         mem_q[req_i.addr] <= req_i.wdata;
      end
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         resp_valid_q <= 1'b0;
      end
      else if (pop)
      begin
         resp_valid_q <= 1'b1;
      end
      else if (resp_grant_i)
      begin
         resp_valid_q <= 1'b0;
      end
   end

   // Output stage payload
   always_ff @(posedge clk)
   begin
      if (pop)
      begin
         resp_q.we   <= req_i.we;
         resp_q.data <= rdata;
      end
   end

   assign resp_o       = resp_q;
   assign resp_valid_o = resp_valid_q;

   // A stalled result stays in place until the response FIFO takes it
   a_stage_held: assert property (@(posedge clk) disable iff (!rst_n)
      (resp_valid_q && !resp_grant_i) |=> (resp_valid_q && $stable(resp_q)))
      else $error("bank_ctrl: output stage overwritten while stalled");

endmodule

//--- bus_pkg.sv
/*
   Bus widths of the memory bank
   Request payload record (write flag, address, write data)
   Response payload record (write flag, data)
*/

package bus_pkg;

   // Word address width gives a 16-word bank
   localparam int ADDR_W = 4;
   localparam int DATA_W = 32;

   // Request as it travels through the request FIFO
   typedef struct packed {
      logic              we;
      logic [ADDR_W-1:0] addr;
      logic [DATA_W-1:0] wdata;
   } req_t;

   // Read word, or the echoed write data when we is set
   typedef struct packed {
      logic              we;
      logic [DATA_W-1:0] data;
   } resp_t;

endpackage

//--- generic_fifo.sv
/*
   Circular-buffer FIFO with a type-parameter payload
   Valid/grant handshake on the push and the pop side
   Empty/middle/full state with wrapping pointers
*/

`timescale 1ns/1ps

module generic_fifo
#(
   parameter int  DATA_DEPTH = 4,
   parameter type T          = logic [31:0]
)
(
   input  logic clk,
   input  logic rst_n,
   // Push side where grant means not full
   input  T     data_i,
   input  logic valid_i,
   output logic grant_o,
   // Pop side where grant is the pop
   output T     data_o,
   output logic valid_o,
   input  logic grant_i
);

   localparam int PTR_W = (DATA_DEPTH > 1) ? $clog2(DATA_DEPTH) : 1;
   localparam logic [PTR_W-1:0] LAST = PTR_W'(DATA_DEPTH - 1);

   typedef enum logic [1:0] {EMPTY, MIDDLE, FULL} state_e;

   state_e           state_q;
   state_e           state_d;
   logic [PTR_W-1:0] push_ptr_q;
   logic [PTR_W-1:0] push_ptr_d;
   logic [PTR_W-1:0] push_ptr_inc;
   logic [PTR_W-1:0] pop_ptr_q;
   logic [PTR_W-1:0] pop_ptr_d;
   logic [PTR_W-1:0] pop_ptr_inc;
   logic             push;
   logic             pop;
   T                 fifo_mem [DATA_DEPTH];

   assign grant_o = (state_q != FULL);
   assign valid_o = (state_q != EMPTY);

   assign push = valid_i && grant_o;
   assign pop  = valid_o && grant_i;

   // Pointers wrap at the last entry
   assign push_ptr_inc = (push_ptr_q == LAST) ? '0 : push_ptr_q + 1'b1;
   assign pop_ptr_inc  = (pop_ptr_q == LAST) ? '0 : pop_ptr_q + 1'b1;

   always_comb
   begin
      state_d    = state_q;
      push_ptr_d = push_ptr_q;
      pop_ptr_d  = pop_ptr_q;

      if (push)
      begin
         push_ptr_d = push_ptr_inc;
      end
      if (pop)
      begin
         pop_ptr_d = pop_ptr_inc;
      end

      case (state_q)
         EMPTY:
         begin
            if (push)
            begin
               state_d = (push_ptr_inc == pop_ptr_q) ? FULL : MIDDLE;
            end
         end
         MIDDLE:
         begin
            // Push and pop together keep the occupancy
            if (push && !pop && (push_ptr_inc == pop_ptr_q))
            begin
               state_d = FULL;
            end
            else if (pop && !push && (pop_ptr_inc == push_ptr_q))
            begin
               state_d = EMPTY;
            end
         end
         FULL:
         begin
            if (pop)
            begin
               state_d = (pop_ptr_inc == push_ptr_q) ? EMPTY : MIDDLE;
            end
         end
         default:
         begin
            state_d    = EMPTY;
            push_ptr_d = '0;
            pop_ptr_d  = '0;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q    <= EMPTY;
         push_ptr_q <= '0;
         pop_ptr_q  <= '0;
      end
      else
      begin
         state_q    <= state_d;
         push_ptr_q <= push_ptr_d;
         pop_ptr_q  <= pop_ptr_d;
      end
   end

   // Entries written on accepted pushes only
   always_ff @(posedge clk)
   begin
      if (push)
      begin
         fifo_mem[push_ptr_q] <= data_i;
      end
   end

   assign data_o = fifo_mem[pop_ptr_q];

   // Equal pointers only when empty or full, so no pop overruns the pushes
   a_ptr_state: assert property (@(posedge clk) disable iff (!rst_n)
      (state_q == MIDDLE) != (push_ptr_q == pop_ptr_q))
      else $error("generic_fifo: pointers disagree with the fill state");

   // Head entry held while waiting for the consumer
   a_data_stable: assert property (@(posedge clk) disable iff (!rst_n)
      (valid_o && !grant_i) |=> (valid_o && $stable(data_o)))
      else $error("generic_fifo: data_o changed while not granted");

endmodule

//--- mem_cfg_pkg.sv
/*
   Default queue depths for the memory bank top level
*/

package mem_cfg_pkg;

   // Request FIFO entries
   localparam int REQ_DEPTH_DEF = 4;

   // Response FIFO entries
   localparam int RESP_DEPTH_DEF = 4;

endpackage

//--- mem_queue_top.sv
/*
   Queued memory bank top level
   Request FIFO, bank controller and response FIFO
*/

`timescale 1ns/1ps

module mem_queue_top
#(
   parameter int REQ_DEPTH  = mem_cfg_pkg::REQ_DEPTH_DEF,
   parameter int RESP_DEPTH = mem_cfg_pkg::RESP_DEPTH_DEF
)
(
   input  logic                       clk,
   input  logic                       rst_n,
   // Request side
   input  logic                       req_valid_i,
   output logic                       req_grant_o,
   input  logic                       req_we_i,
   input  logic [bus_pkg::ADDR_W-1:0] req_addr_i,
   input  logic [bus_pkg::DATA_W-1:0] req_wdata_i,
   // Response side
   output logic                       resp_valid_o,
   input  logic                       resp_grant_i,
   output logic                       resp_we_o,
   output logic [bus_pkg::DATA_W-1:0] resp_rdata_o
);

   import bus_pkg::*;

   req_t  req_in;
   req_t  req_head;
   logic  req_head_valid;
   logic  req_head_grant;
   resp_t bank_resp;
   logic  bank_resp_valid;
   logic  bank_resp_grant;
   resp_t resp_out;

   assign req_in.we    = req_we_i;
   assign req_in.addr  = req_addr_i;
   assign req_in.wdata = req_wdata_i;

   generic_fifo #(.DATA_DEPTH(REQ_DEPTH), .T(req_t)) u_req_fifo (
      .clk(clk), .rst_n(rst_n),
      .data_i(req_in), .valid_i(req_valid_i), .grant_o(req_grant_o),
      .data_o(req_head), .valid_o(req_head_valid), .grant_i(req_head_grant)
   );

   bank_ctrl u_bank (
      .clk(clk), .rst_n(rst_n),
      .req_i(req_head), .req_valid_i(req_head_valid), .req_grant_o(req_head_grant),
      .resp_o(bank_resp), .resp_valid_o(bank_resp_valid), .resp_grant_i(bank_resp_grant)
   );

   generic_fifo #(.DATA_DEPTH(RESP_DEPTH), .T(resp_t)) u_resp_fifo (
      .clk(clk), .rst_n(rst_n),
      .data_i(bank_resp), .valid_i(bank_resp_valid), .grant_o(bank_resp_grant),
      .data_o(resp_out), .valid_o(resp_valid_o), .grant_i(resp_grant_i)
   );

   assign resp_we_o    = resp_out.we;
   assign resp_rdata_o = resp_out.data;

endmodule

//--- tb.f
bus_pkg.sv
mem_cfg_pkg.sv
generic_fifo.sv
bank_ctrl.sv
mem_queue_top.sv
tb_mem_queue.sv

//--- tb_mem_queue.sv
/*
   Testbench for the queued memory bank
   Clock, reset, xorshift stimulus and a reference memory model
   Response scoreboard queue checked by concurrent assertions
*/

`timescale 1ns/1ps

module tb_mem_queue;

   import bus_pkg::*;
   import mem_cfg_pkg::*;

   localparam int REQ_DEPTH  = REQ_DEPTH_DEF;
   localparam int RESP_DEPTH = RESP_DEPTH_DEF;
   localparam int CAPACITY   = REQ_DEPTH + 1 + RESP_DEPTH;
   localparam int WORDS      = 2 ** ADDR_W;
   localparam int WAIT_LIMIT = 200;

   logic              clk;
   logic              rst_n;
   logic              req_valid_i;
   logic              req_grant_o;
   logic              req_we_i;
   logic [ADDR_W-1:0] req_addr_i;
   logic [DATA_W-1:0] req_wdata_i;
   logic              resp_valid_o;
   logic              resp_grant_i;
   logic              resp_we_o;
   logic [DATA_W-1:0] resp_rdata_o;

   // Reference model and scoreboard
   logic [DATA_W-1:0] model_mem [WORDS];
   resp_t             exp_q [$];
   resp_t             expected;
   resp_t             head = '0;
   logic              exp_valid = 1'b0;
   int                in_flight = 0;
   logic              hold_phase = 1'b0;
   logic [31:0]       rng_state = 32'd80076;

   mem_queue_top #(.REQ_DEPTH(REQ_DEPTH), .RESP_DEPTH(RESP_DEPTH)) dut0 (
      .clk(clk), .rst_n(rst_n),
      .req_valid_i(req_valid_i), .req_grant_o(req_grant_o),
      .req_we_i(req_we_i), .req_addr_i(req_addr_i), .req_wdata_i(req_wdata_i),
      .resp_valid_o(resp_valid_o), .resp_grant_i(resp_grant_i),
      .resp_we_o(resp_we_o), .resp_rdata_o(resp_rdata_o)
   );

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] next_rand();
      rng_state = xorshift(rng_state);
      return rng_state;
   endfunction

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Result: FAILED");
      $fatal(1, "simulation stopped");
   endtask

   task automatic report_mismatch(input string msg);
      abort_run($sformatf("mismatch at %0t ns: %s", $time, msg));
   endtask

   // One clock and then the drive point after the edge
   task automatic step();
      @(posedge clk);
      #5;
   endtask

   task automatic send_req(input logic we, input logic [ADDR_W-1:0] addr,
                           input logic [DATA_W-1:0] data);
      int waited;
      waited = 0;
      req_valid_i = 1'b1;
      req_we_i    = we;
      req_addr_i  = addr;
      req_wdata_i = data;
      while (!req_grant_o)
      begin
         step();
         waited++;
         if (waited > WAIT_LIMIT)
            abort_run("request was never accepted by the DUT");
      end
      step();
      req_valid_i = 1'b0;
   endtask

   task automatic wait_drained();
      int waited;
      waited = 0;
      while (in_flight != 0 || resp_valid_o)
      begin
         step();
         waited++;
         if (waited > WAIT_LIMIT)
            abort_run("outstanding responses did not drain");
      end
   endtask

   task automatic fill_under_backpressure();
      int waited;
      waited = 0;
      hold_phase   = 1'b1;
      resp_grant_i = 1'b0;
      while (req_grant_o)
      begin
         req_valid_i = 1'b1;
         req_we_i    = 1'(next_rand());
         req_addr_i  = ADDR_W'(next_rand());
         req_wdata_i = next_rand();
         step();
         waited++;
         if (waited > WAIT_LIMIT)
            abort_run("request grant never dropped while responses were stalled");
      end
      req_valid_i = 1'b0;
      // Stall a while so the held response is watched
      repeat (12) step();
      hold_phase   = 1'b0;
      resp_grant_i = 1'b1;
   endtask

   task automatic run_random(input int count);
      int          sent;
      int          cycles;
      logic        accepted;
      logic [31:0] r;
      sent   = 0;
      cycles = 0;
      while (sent < count)
      begin
         r = next_rand();
         if (!req_valid_i && r[1:0] != 2'b00)
         begin
            req_valid_i = 1'b1;
            req_we_i    = r[2];
            req_addr_i  = r[7:4];
            req_wdata_i = next_rand();
         end
         resp_grant_i = (r[9:8] != 2'b00);
         accepted     = req_valid_i && req_grant_o;
         step();
         if (accepted)
         begin
            req_valid_i = 1'b0;
            sent++;
         end
         cycles++;
         if (cycles > count * 20)
            abort_run("random traffic made no progress");
      end
      req_valid_i  = 1'b0;
      resp_grant_i = 1'b1;
   endtask

   // Model follows acceptance order
   // Scoreboard pops along with the outside
   always @(posedge clk)
   begin
      if (!rst_n)
      begin
         exp_q.delete();
         for (int i = 0; i < WORDS; i++)
            model_mem[i] = '0;
      end
      else
      begin
         if (resp_valid_o && resp_grant_i && exp_q.size() > 0)
            void'(exp_q.pop_front());
         if (req_valid_i && req_grant_o)
         begin
            expected.we = req_we_i;
            if (req_we_i)
            begin
               model_mem[req_addr_i] = req_wdata_i;
               expected.data = req_wdata_i;
            end
            else
               expected.data = model_mem[req_addr_i];
            exp_q.push_back(expected);
         end
      end
      in_flight = exp_q.size();
      exp_valid = (in_flight > 0);
      head      = exp_valid ? exp_q[0] : '0;
   end

   a_reset_state: assert property (@(posedge clk)
      $past(!rst_n) |-> (!resp_valid_o && req_grant_o))
      else report_mismatch("reset state wrong on resp_valid_o or req_grant_o");

   a_no_extra_resp: assert property (@(posedge clk) disable iff (!rst_n)
      !exp_valid |-> !resp_valid_o)
      else report_mismatch("response offered with no request outstanding");

   a_resp_match: assert property (@(posedge clk) disable iff (!rst_n)
      (resp_valid_o && resp_grant_i) |-> (resp_we_o == head.we && resp_rdata_o == head.data))
      else report_mismatch($sformatf("response we=%0b data=%h, expected we=%0b data=%h",
         $sampled(resp_we_o), $sampled(resp_rdata_o), $sampled(head.we),
         $sampled(head.data)));

   a_resp_stable: assert property (@(posedge clk) disable iff (!rst_n)
      (resp_valid_o && !resp_grant_i) |=>
         (resp_valid_o && $stable(resp_rdata_o) && $stable(resp_we_o)))
      else report_mismatch("response changed while not granted");

   a_full_count: assert property (@(posedge clk) disable iff (!rst_n)
      (hold_phase && !req_grant_o) |-> (in_flight == CAPACITY))
      else report_mismatch($sformatf("request grant dropped after %0d requests",
         $sampled(in_flight)));

   a_full_blocks: assert property (@(posedge clk) disable iff (!rst_n)
      (in_flight == CAPACITY) |-> !req_grant_o)
      else report_mismatch("request grant high with the queue full");

   initial
   begin
      logic [DATA_W-1:0] wr_data;
      logic [ADDR_W-1:0] wr_addr;
      rst_n        = 1'b0;
      req_valid_i  = 1'b0;
      req_we_i     = 1'b0;
      req_addr_i   = '0;
      req_wdata_i  = '0;
      resp_grant_i = 1'b1;
      repeat (16) @(posedge clk);
      #5;
      rst_n = 1'b1;
      step();

      // Every word reads zero after reset
      for (int a = 0; a < WORDS; a++)
         send_req(1'b0, ADDR_W'(a), next_rand());
      wait_drained();

      // Write then read back
      for (int k = 0; k < 6; k++)
      begin
         wr_data = next_rand();
         wr_addr = ADDR_W'(next_rand());
         send_req(1'b1, wr_addr, wr_data);
         send_req(1'b0, wr_addr, next_rand());
      end
      wait_drained();

      // Mixed stream with full output flow
      for (int k = 0; k < 40; k++)
         send_req(1'(next_rand()), ADDR_W'(next_rand()), next_rand());
      wait_drained();

      fill_under_backpressure();
      wait_drained();

      run_random(400);
      wait_drained();

      $display("Result: PASSED");
      $finish;
   end

endmodule
